// File: hw/rv_branch_defines.svh
// RV32I branch unit constants
// data width, reset vector and the opcode and funct3 encodings
// for conditional branches and JAL

`ifndef RV_BRANCH_DEFINES_SVH
`define RV_BRANCH_DEFINES_SVH

// datapath and address width
`define XLEN        32

// pc after reset
`define RESET_PC    32'h0000_1000

// major opcodes, instr[6:0]
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

// branch condition codes, instr[14:12]
// 010 and 011 are unused
`define FNC_BEQ     3'b000
`define FNC_BNE     3'b001
`define FNC_BLT     3'b100
`define FNC_BGE     3'b101
`define FNC_BLTU    3'b110
`define FNC_BGEU    3'b111

`endif

// File: hw/rv_branch_pkg.sv
// RV32I branch unit types
// vector types shared by the decoder, resolver and pc controller,
// plus the handshake FSM state encoding

`include "rv_branch_defines.svh"

package rv_branch_pkg;

    // addresses, register operands and immediates
    typedef logic [`XLEN-1:0] xlen_t;

    // raw instruction word, always 32 bits in RV32I
    typedef logic [31:0] instr_t;

    // branch condition field
    typedef logic [2:0] funct3_t;

    // handshake controller
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        RESOLVE = 2'd1,
        DONE    = 2'd2
    } ctrl_state_e;

endpackage

// File: hw/branch_if.sv
// Branch resolution bus
// carries the latched instruction, operands and pc from the controller
// through the decoder to the resolver, and the result back

`timescale 1ns/100ps

interface branch_if;
    import rv_branch_pkg::*;

    // registered in the controller
    instr_t  instr;
    xlen_t   pc;
    xlen_t   rs1;
    xlen_t   rs2;

    // decoder results
    xlen_t   imm;
    funct3_t funct3;
    logic    is_branch;
    logic    is_jump;

    // resolver results
    xlen_t   target;
    logic    taken;

    modport ctrl (
        output instr, pc, rs1, rs2,
        input  target, taken
    );

    modport dec (
        input  instr,
        output imm, funct3, is_branch, is_jump
    );

    modport res (
        input  pc, imm, rs1, rs2, funct3, is_branch, is_jump,
        output target, taken
    );

endinterface

// File: hw/branch_decode.sv
// Branch decoder
// classifies the latched instruction as conditional branch or JAL
// and builds the sign-extended B or J immediate

`timescale 1ns/100ps
`include "rv_branch_defines.svh"

module branch_decode (
    branch_if.dec br
);
    import rv_branch_pkg::*;

    logic [6:0] opcode;
    xlen_t      b_imm;
    xlen_t      j_imm;

    assign opcode = br.instr[6:0];

    // B-type: 13-bit offset, bit 0 implied zero
    assign b_imm = {
        {(`XLEN-12){br.instr[31]}},
        br.instr[7],
        br.instr[30:25],
        br.instr[11:8],
        1'b0
    };

    // J-type: 21-bit offset, bit 0 implied zero
    assign j_imm = {
        {(`XLEN-20){br.instr[31]}},
        br.instr[19:12],
        br.instr[20],
        br.instr[30:21],
        1'b0
    };

    // condition code goes through untouched, resolver gates it
    assign br.funct3 = br.instr[14:12];

    always_comb begin
        br.imm       = '0;
        br.is_branch = 1'b0;
        br.is_jump   = 1'b0;
        case (opcode)
            `OPC_BRANCH: begin
                br.imm       = b_imm;
                br.is_branch = 1'b1;
            end
            `OPC_JAL: begin
                br.imm     = j_imm;
                br.is_jump = 1'b1;
            end
            default: begin
                // anything else just falls through to pc+4
                br.imm       = '0;
                br.is_branch = 1'b0;
                br.is_jump   = 1'b0;
            end
        endcase
    end

endmodule

// File: hw/branch_target.sv
// Branch resolver
// adds the immediate to the pc and evaluates the branch condition,
// signed or unsigned as funct3 selects

`timescale 1ns/100ps
`include "rv_branch_defines.svh"

module branch_target (
    branch_if.res br
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    // same adder serves B and J targets
    assign br.target = br.pc + br.imm;

    assign eq   = (br.rs1 == br.rs2);
    assign lt_s = ($signed(br.rs1) < $signed(br.rs2));
    assign lt_u = (br.rs1 < br.rs2);

    always_comb begin
        case (br.funct3)
            `FNC_BEQ:  cond = eq;
            `FNC_BNE:  cond = ~eq;
            `FNC_BLT:  cond = lt_s;
            `FNC_BGE:  cond = ~lt_s;
            `FNC_BLTU: cond = lt_u;
            `FNC_BGEU: cond = ~lt_u;
            // 010 and 011 never branch
            default:   cond = 1'b0;
        endcase
    end

    // jal always taken, branches only on their condition
    assign br.taken = br.is_jump | (br.is_branch & cond);

endmodule

// File: hw/pc_control.sv
// PC controller
// four-phase req/ack handshake, latches the instruction and operands,
// and commits the resolved next pc and taken flag

`timescale 1ns/100ps
`include "rv_branch_defines.svh"

module pc_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  rv_branch_pkg::instr_t instr,
    input  rv_branch_pkg::xlen_t  rs1_val,
    input  rv_branch_pkg::xlen_t  rs2_val,
    output logic                  ack,
    output rv_branch_pkg::xlen_t  pc,
    output logic                  taken,
    branch_if.ctrl                br
);
    import rv_branch_pkg::*;

    ctrl_state_e state;
    logic        capture;
    instr_t      instr_q;
    xlen_t       rs1_q;
    xlen_t       rs2_q;
    xlen_t       pc_plus4;
    xlen_t       next_pc;

    // first edge with req seen in IDLE
    assign capture = (state == IDLE) && req;

    // request payload, held for the resolve cycle
    always_ff @(posedge clk) begin
        if (capture) begin
            instr_q <= instr;
            rs1_q   <= rs1_val;
            rs2_q   <= rs2_val;
        end
    end

    // drive the resolution bus straight from the registers
    assign br.instr = instr_q;
    assign br.rs1   = rs1_q;
    assign br.rs2   = rs2_q;
    assign br.pc    = pc;

    assign pc_plus4 = pc + `XLEN'd4;
    assign next_pc  = br.taken ? br.target : pc_plus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            pc    <= `RESET_PC;
            ack   <= 1'b0;
            taken <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= RESOLVE;
                    end
                end
                RESOLVE: begin
                    // single pc update per transaction
                    pc    <= next_pc;
                    taken <= br.taken;
                    ack   <= 1'b1;
                    state <= DONE;
                end
                DONE: begin
                    // hold ack until the requester lets go
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    ack   <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/branch_unit_top.sv
// Branch unit top level
// pc controller, decoder and resolver joined by the branch bus

`timescale 1ns/100ps

module branch_unit_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  rv_branch_pkg::instr_t instr,
    input  rv_branch_pkg::xlen_t  rs1_val,
    input  rv_branch_pkg::xlen_t  rs2_val,
    output logic                  ack,
    output rv_branch_pkg::xlen_t  pc,
    output logic                  taken
);

    branch_if br_bus ();

    // handshake, registers and pc update
    pc_control u_pc_control (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .instr   (instr),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .ack     (ack),
        .pc      (pc),
        .taken   (taken),
        .br      (br_bus.ctrl)
    );

    // opcode and immediate
    branch_decode u_branch_decode (
        .br (br_bus.dec)
    );

    // target adder and comparator
    branch_target u_branch_target (
        .br (br_bus.res)
    );

endmodule

// File: verification/tb_branch_unit.sv
// Branch unit testbench
// directed and seeded random requests over the req/ack handshake,
// checked against a reference model of the RV32I branch rules

`timescale 1ns/100ps
`include "rv_branch_defines.svh"

module tb_branch_unit;
    import rv_branch_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 10;
    localparam int RAND_REQS       = 16;
    localparam int DIRECTED_REQS   = 20;
    localparam int ACK_LIMIT       = 8;
    localparam int WATCHDOG_CYCLES = (DIRECTED_REQS + RAND_REQS) * 10 + RESET_CYCLES;

    logic   clk;
    logic   rst;
    logic   req;
    instr_t instr;
    xlen_t  rs1_val;
    xlen_t  rs2_val;
    logic   ack;
    xlen_t  pc;
    logic   taken;

    int     errors;
    xlen_t  exp_pc;

    branch_unit_top DUT (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .instr   (instr),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .ack     (ack),
        .pc      (pc),
        .taken   (taken)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // instruction encoders, offset fields scattered as in the ISA manual
    function automatic instr_t enc_b(input funct3_t f3, input xlen_t off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic instr_t enc_j(input xlen_t off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, `OPC_JAL};
    endfunction

    function automatic instr_t enc_other(input logic [6:0] opc, input funct3_t f3);
        return {7'd0, 5'd2, 5'd1, f3, 5'd3, opc};
    endfunction

    // reference model of the taken decision
    function automatic logic predict_taken(input logic [6:0] opc, input funct3_t f3,
                                           input xlen_t a, input xlen_t b);
        logic lt_u;
        logic lt_s;
        lt_u = a < b;
        // flipping the sign bit turns a signed compare into an unsigned one
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        if (opc == `OPC_JAL)
            return 1'b1;
        if (opc != `OPC_BRANCH)
            return 1'b0;
        case (f3)
            `FNC_BEQ:  return a == b;
            `FNC_BNE:  return a != b;
            `FNC_BLT:  return lt_s;
            `FNC_BGE:  return !lt_s;
            `FNC_BLTU: return lt_u;
            `FNC_BGEU: return !lt_u;
            default:   return 1'b0;
        endcase
    endfunction

    // one four-phase transaction, called on a falling edge
    task automatic do_request(input string name, input instr_t ins, input xlen_t a,
                              input xlen_t b, input int hold,
                              output xlen_t got_pc, output logic got_taken);
        int edges;
        check({name, " ack idle"}, 32'd0, xlen_t'(ack));
        instr   = ins;
        rs1_val = a;
        rs2_val = b;
        req     = 1'b1;
        edges   = 0;
        while (!ack && edges < ACK_LIMIT) begin
            @(negedge clk);
            edges++;
        end
        got_pc    = pc;
        got_taken = taken;
        if (!ack) begin
            errors++;
            $display("%s: DUT never raised ack within %0d cycles", name, ACK_LIMIT);
        end else begin
            check({name, " ack latency"}, 32'd2, xlen_t'(edges));
            repeat (hold) begin
                @(negedge clk);
                check({name, " ack held"}, 32'd1, xlen_t'(ack));
                check({name, " pc held"}, got_pc, pc);
                check({name, " taken held"}, xlen_t'(got_taken), xlen_t'(taken));
            end
        end
        req = 1'b0;
        @(negedge clk);
        check({name, " ack drop"}, 32'd0, xlen_t'(ack));
        check({name, " pc after drop"}, got_pc, pc);
        check({name, " taken after drop"}, xlen_t'(got_taken), xlen_t'(taken));
    endtask

    task automatic issue(input string name, input logic [6:0] opc, input funct3_t f3,
                         input xlen_t off, input xlen_t a, input xlen_t b, input int hold);
        instr_t ins;
        logic   exp_taken;
        xlen_t  got_pc;
        logic   got_taken;
        if (opc == `OPC_JAL)
            ins = enc_j(off);
        else if (opc == `OPC_BRANCH)
            ins = enc_b(f3, off);
        else
            ins = enc_other(opc, f3);
        exp_taken = predict_taken(opc, f3, a, b);
        exp_pc    = exp_taken ? exp_pc + off : exp_pc + 32'd4;
        do_request(name, ins, a, b, hold, got_pc, got_taken);
        check({name, " taken"}, xlen_t'(exp_taken), xlen_t'(got_taken));
        check({name, " pc"}, exp_pc, got_pc);
    endtask

    task automatic test_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check("reset ack", 32'd0, xlen_t'(ack));
        check("reset taken", 32'd0, xlen_t'(taken));
        check("reset pc", `RESET_PC, pc);
        exp_pc = `RESET_PC;
    endtask

    task automatic test_beq_bne();
        logic [31:0] rnd;
        xlen_t       a;
        xlen_t       b;
        xlen_t       off;
        issue("beq equal", `OPC_BRANCH, `FNC_BEQ, 32'h40, 32'h1234, 32'h1234, 0);
        issue("beq unequal", `OPC_BRANCH, `FNC_BEQ, 32'h40, 32'h1234, 32'h1235, 0);
        issue("bne equal", `OPC_BRANCH, `FNC_BNE, 32'h80, 32'd7, 32'd7, 0);
        issue("bne unequal", `OPC_BRANCH, `FNC_BNE, 32'h80, 32'd7, 32'd8, 0);
        for (int i = 0; i < RAND_REQS; i++) begin
            rnd = $urandom;
            a   = $urandom;
            b   = rnd[1] ? a : xlen_t'($urandom);
            off = {{19{rnd[13]}}, rnd[13:2], 1'b0};
            issue($sformatf("random beq/bne %0d", i), `OPC_BRANCH,
                  rnd[0] ? `FNC_BNE : `FNC_BEQ, off, a, b, 0);
        end
    endtask

    // 8000_0001 is negative when signed, large when unsigned
    task automatic test_signedness();
        issue("blt neg<1", `OPC_BRANCH, `FNC_BLT, 32'h100, 32'h8000_0001, 32'd1, 0);
        issue("bge neg<1", `OPC_BRANCH, `FNC_BGE, 32'h100, 32'h8000_0001, 32'd1, 0);
        issue("bltu big>1", `OPC_BRANCH, `FNC_BLTU, 32'h100, 32'h8000_0001, 32'd1, 0);
        issue("bgeu big>1", `OPC_BRANCH, `FNC_BGEU, 32'h100, 32'h8000_0001, 32'd1, 0);
        issue("blt 1>neg", `OPC_BRANCH, `FNC_BLT, 32'h100, 32'd1, 32'h8000_0001, 0);
        issue("bge 1>neg", `OPC_BRANCH, `FNC_BGE, 32'h100, 32'd1, 32'h8000_0001, 0);
        issue("bltu 1<big", `OPC_BRANCH, `FNC_BLTU, 32'h100, 32'd1, 32'h8000_0001, 0);
        issue("bgeu 1<big", `OPC_BRANCH, `FNC_BGEU, 32'h100, 32'd1, 32'h8000_0001, 0);
    endtask

    task automatic test_jal_other();
        xlen_t old_pc;
        issue("jal forward", `OPC_JAL, 3'b000, 32'h0000_2000, 32'd0, 32'd0, 0);
        issue("jal backward", `OPC_JAL, 3'b000, 32'hFFFF_F000, 32'd0, 32'd0, 0);
        old_pc = exp_pc;
        issue("beq backward", `OPC_BRANCH, `FNC_BEQ, 32'hFFFF_FF00, 32'd5, 32'd5, 0);
        check("beq backward lower pc", 32'd1, xlen_t'(pc < old_pc));
        issue("r-type opcode", 7'b0110011, `FNC_BEQ, 32'd0, 32'd9, 32'd9, 0);
        issue("funct3 010", `OPC_BRANCH, 3'b010, 32'h40, 32'd9, 32'd9, 0);
        issue("funct3 011", `OPC_BRANCH, 3'b011, 32'h40, 32'd9, 32'd9, 0);
    endtask

    task automatic test_handshake();
        issue("backpressure", `OPC_BRANCH, `FNC_BNE, 32'h20, 32'd1, 32'd2, 4);
        issue("after backpressure", `OPC_JAL, 3'b000, 32'h10, 32'd0, 32'd0, 0);
    endtask

    initial begin
        rst     = 1'b1;
        req     = 1'b0;
        instr   = '0;
        rs1_val = '0;
        rs2_val = '0;
        errors  = 0;
        exp_pc  = `RESET_PC;
        void'($urandom(16));

        test_reset();
        test_beq_bne();
        test_signedness();
        test_jal_other();
        test_handshake();

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+hw
hw/rv_branch_pkg.sv
hw/branch_if.sv
hw/branch_decode.sv
hw/branch_target.sv
hw/pc_control.sv
hw/branch_unit_top.sv
verification/tb_branch_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the branch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_branch_unit
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_branch_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
